// File: build.f
conv_pkg.sv
conv_ctrl.sv
kernel_window.sv
majority_vote.sv
row_packer.sv
conv_top.sv
conv_props.sv
conv_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps --top-module conv_tb \
	-f build.f -o conv_tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "verilator build failed"
	exit 1
fi

./obj_dir/conv_tb_sim +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Test failures found" sim.log; then
	exit 1
fi
exit 0

// File: conv_tb.sv
// testbench for conv_top: clock, reset, memory models, random batches, reference model, watchdog
module conv_tb
	import conv_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	// worst case is five matrices of fourteen output rows
	localparam int MAX_ROWS = 128;
	localparam int MEM_WORDS = 4096;

	logic clk = 1'b0;
	logic reset_b;
	logic dut_run;
	logic [ROW_W-1:0] sram_dut_read_data = '0;
	logic [ROW_W-1:0] wmem_dut_read_data = '0;
	logic dut_busy;
	logic dut_sram_write_enable;
	logic [ADDR_W-1:0] dut_sram_read_address;
	logic [ADDR_W-1:0] dut_wmem_read_address;
	logic [ADDR_W-1:0] dut_sram_write_address;
	logic [ROW_W-1:0] dut_sram_write_data;

	// input, weight and expected output memories
	logic [ROW_W-1:0] in_mem [0:MEM_WORDS-1];
	logic [ROW_W-1:0] w_mem [0:MEM_WORDS-1];
	logic [ROW_W-1:0] exp_mem [0:MAX_ROWS-1];
	// writes seen per output address
	int wr_count [0:MAX_ROWS-1];
	int exp_count;
	int in_words;
	integer seed;
	int mismatch_errors;
	int other_errors;
	int assert_errors;
	logic [ROW_W-1:0] prev_rdata;

	// watchdog bookkeeping in clock cycles
	int cycle_count = 0;
	int wd_start = 0;
	int wd_limit = 0;
	logic wd_armed = 1'b0;

	always #2 clk = ~clk;

	always @(posedge clk) cycle_count <= cycle_count + 1;

	// synchronous SRAMs, data one clock after the address
	always @(posedge clk) begin
		sram_dut_read_data <= in_mem[dut_sram_read_address];
		wmem_dut_read_data <= w_mem[dut_wmem_read_address];
	end

	conv_top i_conv_top (
		.clk(clk),
		.reset_b(reset_b),
		.dut_run(dut_run),
		.sram_dut_read_data(sram_dut_read_data),
		.wmem_dut_read_data(wmem_dut_read_data),
		.dut_busy(dut_busy),
		.dut_sram_write_enable(dut_sram_write_enable),
		.dut_sram_read_address(dut_sram_read_address),
		.dut_wmem_read_address(dut_wmem_read_address),
		.dut_sram_write_address(dut_sram_write_address),
		.dut_sram_write_data(dut_sram_write_data)
	);

	function automatic int rand_range(input int lo, input int hi);
		rand_range = lo + int'($unsigned($random(seed)) % (hi - lo + 1));
	endfunction

	// lay out one batch and compute the expected output rows
	task automatic fill_batch(input int batch);
		int a;
		int m;
		int r;
		int s;
		int i;
		int j;
		int addr;
		int n_mat;
		int rows;
		int cols;
		int mism;
		logic [8:0] kern;
		logic [ROW_W-1:0] word;
		// background pattern, unique per address
		for (a = 0; a < MEM_WORDS; a++) begin
			in_mem[a] = {4'h5, 12'(a)};
			w_mem[a] = {4'h3, 12'(a)};
		end
		kern = 9'($random(seed));
		w_mem[KERNEL_ADDR] = {7'b0, kern};
		n_mat = rand_range(3, 5);
		addr = 0;
		exp_count = 0;
		for (m = 0; m < n_mat; m++) begin
			// first two matrices pin the size extremes
			if (m == 0) begin
				rows = (batch == 0) ? 3 : 16;
				cols = rows;
			end else if (m == 1) begin
				rows = rand_range(3, 16);
				cols = (batch == 0) ? 16 : 3;
			end else begin
				rows = rand_range(3, 16);
				cols = rand_range(3, 16);
			end
			in_mem[addr] = 16'(rows);
			in_mem[addr + 1] = 16'(cols);
			for (r = 0; r < rows; r++) begin
				in_mem[addr + 2 + r] = 16'($random(seed));
			end
			// positive unless five or more pixel bits differ from their weights
			for (r = 0; r <= rows - 3; r++) begin
				word = '0;
				for (s = 0; s <= cols - 3; s++) begin
					mism = 0;
					for (i = 0; i < 3; i++) begin
						for (j = 0; j < 3; j++) begin
							if (in_mem[addr + 2 + r + i][s + j] != kern[3 * i + j]) begin
								mism++;
							end
						end
					end
					if (mism < 5) begin
						word[s] = 1'b1;
					end
				end
				exp_mem[exp_count] = word;
				exp_count++;
			end
			addr = addr + 2 + rows;
		end
		in_mem[addr] = END_MARKER;
		in_words = addr + 1;
	endtask

	// output memory write port, one write per strobe
	task automatic check_write();
		int a;
		if (dut_sram_write_enable === 1'b1) begin
			a = int'(dut_sram_write_address);
			if (a >= exp_count) begin
				other_errors++;
				$display("ERROR at %0t: write to address %0d, only %0d rows expected",
					$time, a, exp_count);
			end else begin
				if (wr_count[a] != 0) begin
					other_errors++;
					$display("ERROR at %0t: output address %0d written more than once", $time, a);
				end
				if (dut_sram_write_data !== exp_mem[a]) begin
					mismatch_errors++;
					$display("MISMATCH at %0t: row %0d got %h expected %h",
						$time, a, dut_sram_write_data, exp_mem[a]);
				end
				wr_count[a]++;
			end
		end
	endtask

	// start a batch and follow it until busy falls
	task automatic run_batch();
		int a;
		for (a = 0; a < MAX_ROWS; a++) begin
			wr_count[a] = 0;
		end
		@(negedge clk);
		if (dut_busy !== 1'b0) begin
			other_errors++;
			$display("ERROR at %0t: dut_busy high before dut_run", $time);
		end
		wd_start = cycle_count;
		wd_limit = 40 * in_words + 200;
		wd_armed = 1'b1;
		dut_run = 1'b1;
		@(negedge clk);
		dut_run = 1'b0;
		if (dut_busy !== 1'b1) begin
			other_errors++;
			$display("ERROR at %0t: dut_busy did not rise one cycle after dut_run", $time);
		end
		while (dut_busy === 1'b1) begin
			check_write();
			prev_rdata = sram_dut_read_data;
			@(negedge clk);
		end
		wd_armed = 1'b0;
		// last word fetched before the fall
		if (prev_rdata !== END_MARKER) begin
			other_errors++;
			$display("ERROR at %0t: dut_busy fell before the end marker was read", $time);
		end
		for (a = 0; a < exp_count; a++) begin
			if (wr_count[a] == 0) begin
				other_errors++;
				$display("ERROR at %0t: output row %0d never written", $time, a);
			end
		end
	endtask

	initial begin
		seed = 32'hc34333c7;
		reset_b = 1'b0;
		dut_run = 1'b0;
		mismatch_errors = 0;
		other_errors = 0;
		prev_rdata = '0;
		fill_batch(0);
		repeat (2) @(negedge clk);
		if (dut_busy !== 1'b0 || dut_sram_write_enable !== 1'b0) begin
			other_errors++;
			$display("ERROR at %0t: busy or write enable not low in reset", $time);
		end
		reset_b = 1'b1;
		@(negedge clk);
		if (dut_busy !== 1'b0 || dut_sram_write_enable !== 1'b0) begin
			other_errors++;
			$display("ERROR at %0t: busy or write enable not low after reset", $time);
		end
		run_batch();
		// new contents, output rows count again from 0
		fill_batch(1);
		run_batch();
		repeat (4) @(negedge clk);
		assert_errors = i_conv_top.i_conv_props.failures;
		$display("errors: %0d mismatch, %0d other, %0d assertion",
			mismatch_errors, other_errors, assert_errors);
		if (mismatch_errors + other_errors + assert_errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	// limit scales with the input words of the running batch
	initial begin
		while (!(wd_armed === 1'b1 && (cycle_count - wd_start) > wd_limit)) begin
			@(posedge clk);
		end
		$display("ERROR: timeout, dut_busy still high after %0d cycles", wd_limit);
		$display("Test failures found");
		$finish;
	end

endmodule

// File: conv_props.sv
// concurrent assertions on the output write strobe and busy, bound into conv_top
module conv_props (
	input logic clk,
	input logic reset_b,
	input logic dut_busy,
	input logic dut_sram_write_enable
);

	timeunit 1ns;
	timeprecision 100ps;

	// number of failed assertions
	int failures = 0;

	// strobe lasts a single cycle
	write_single_cycle: assert property (@(posedge clk) disable iff (!reset_b)
		dut_sram_write_enable |=> !dut_sram_write_enable)
	else begin
		$error("write enable high for two cycles in a row");
		failures++;
	end

	// quiet write port in reset
	write_low_in_reset: assert property (@(posedge clk)
		!reset_b |-> !dut_sram_write_enable)
	else begin
		$error("write enable high during reset");
		failures++;
	end

	// writes only inside a batch
	write_while_busy: assert property (@(posedge clk) disable iff (!reset_b)
		dut_sram_write_enable |-> dut_busy)
	else begin
		$error("write while dut_busy low");
		failures++;
	end

endmodule

bind conv_top conv_props i_conv_props (
	.clk(clk),
	.reset_b(reset_b),
	.dut_busy(dut_busy),
	.dut_sram_write_enable(dut_sram_write_enable)
);

// File: conv_top.sv
// binary 3x3 convolution engine top level
module conv_top import conv_pkg::*; (
	input logic clk,
	input logic reset_b,
	input logic dut_run,
	input logic [ROW_W-1:0] sram_dut_read_data,
	input logic [ROW_W-1:0] wmem_dut_read_data,
	output logic dut_busy,
	output logic dut_sram_write_enable,
	output logic [ADDR_W-1:0] dut_sram_read_address,
	output logic [ADDR_W-1:0] dut_wmem_read_address,
	output logic [ADDR_W-1:0] dut_sram_write_address,
	output logic [ROW_W-1:0] dut_sram_write_data
);

	col_sample_t sample;
	vote_item_t item;
	result_t result;
	logic [8:0] kernel;
	logic packer_idle;

	// sequencer and row buffer
	conv_ctrl i_conv_ctrl (
		.clk(clk),
		.reset_b(reset_b),
		.dut_run(dut_run),
		.sram_dut_read_data(sram_dut_read_data),
		.wmem_dut_read_data(wmem_dut_read_data),
		.packer_idle(packer_idle),
		.dut_busy(dut_busy),
		.dut_sram_read_address(dut_sram_read_address),
		.dut_wmem_read_address(dut_wmem_read_address),
		.sample(sample),
		.kernel(kernel)
	);

	// sample to window, one cycle
	kernel_window i_kernel_window (
		.clk(clk),
		.reset_b(reset_b),
		.sample(sample),
		.kernel(kernel),
		.item(item)
	);

	// window to decided bit, two cycles
	majority_vote i_majority_vote (
		.clk(clk),
		.reset_b(reset_b),
		.item(item),
		.result(result)
	);

	// bit to output row write, one cycle
	row_packer i_row_packer (
		.clk(clk),
		.reset_b(reset_b),
		.result(result),
		.dut_sram_write_enable(dut_sram_write_enable),
		.dut_sram_write_address(dut_sram_write_address),
		.dut_sram_write_data(dut_sram_write_data),
		.packer_idle(packer_idle)
	);

endmodule

// File: row_packer.sv
// output row assembly and one-cycle write to output memory
module row_packer import conv_pkg::*; (
	input logic clk,
	input logic reset_b,
	input result_t result,
	output logic dut_sram_write_enable,
	output logic [ADDR_W-1:0] dut_sram_write_address,
	output logic [ROW_W-1:0] dut_sram_write_data,
	output logic packer_idle
);

	// row under construction
	logic [ROW_W-1:0] row_q;
	logic [ROW_W-1:0] row_next;
	// some bits of a row already taken in
	logic assembling;

	// OR the arriving bit into its column
	always_comb begin
		row_next = row_q;
		if (result.valid) begin
			row_next = row_q | (ROW_W'(result.pos) << result.col);
		end
	end

	// arriving result counts as pending work
	assign packer_idle = !assembling && !dut_sram_write_enable && !result.valid;

	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			row_q <= '0;
			assembling <= 1'b0;
			dut_sram_write_enable <= 1'b0;
			dut_sram_write_address <= '0;
			dut_sram_write_data <= '0;
		end else begin
			// strobe lasts one cycle
			dut_sram_write_enable <= result.valid && result.row_end;
			if (result.valid && result.row_end) begin
				// finished row goes out, register starts over
				dut_sram_write_address <= result.waddr;
				dut_sram_write_data <= row_next;
				row_q <= '0;
				assembling <= 1'b0;
			end else if (result.valid) begin
				row_q <= row_next;
				assembling <= 1'b1;
			end
		end
	end

endmodule

// File: majority_vote.sv
// two-stage full-adder count of nine mismatches and sign decision
module majority_vote import conv_pkg::*; (
	input logic clk,
	input logic reset_b,
	input vote_item_t item,
	output result_t result
);

	// stage one, bits[2:0] ones and bits[5:3] twos per kernel row
	vote_item_t s1;
	// stage two adder outputs
	logic [1:0] fa_ones;
	logic [1:0] fa_twos;
	logic [3:0] count;

	// returns {carry, sum}
	function automatic logic [1:0] full_add(input logic a, input logic b, input logic c);
		full_add = {(a & b) | (c & (a ^ b)), a ^ b ^ c};
	endfunction

	// ones column gives weight 1 and 2, twos column gives 2 and 4
	always_comb begin
		fa_ones = full_add(s1.bits[0], s1.bits[1], s1.bits[2]);
		fa_twos = full_add(s1.bits[3], s1.bits[4], s1.bits[5]);
		count = 4'(fa_ones[0]) + 4'({fa_ones[1], 1'b0}) + 4'({fa_twos[0], 1'b0})
			+ 4'({fa_twos[1], 2'b00});
	end

	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			s1 <= '0;
			result <= '0;
		end else begin
			// side fields ride along
			s1.valid <= item.valid;
			s1.col <= item.col;
			s1.waddr <= item.waddr;
			s1.row_end <= item.row_end;
			// one full adder per kernel row
			for (int i = 0; i < 3; i++) begin
				{s1.bits[3+i], s1.bits[i]} <= full_add(item.bits[3*i], item.bits[3*i+1],
					item.bits[3*i+2]);
			end
			s1.bits[8:6] <= '0;
			result.valid <= s1.valid;
			result.col <= s1.col;
			result.waddr <= s1.waddr;
			result.row_end <= s1.row_end;
			// positive unless a majority of products are negative
			result.pos <= (count < 4'(MISMATCH_LIMIT));
		end
	end

endmodule

// File: kernel_window.sv
// three-column shift window and kernel mismatch vector
module kernel_window import conv_pkg::*; (
	input logic clk,
	input logic reset_b,
	input col_sample_t sample,
	input logic [8:0] kernel,
	output vote_item_t item
);

	// previous column and the one before it
	logic [2:0] col_m1;
	logic [2:0] col_m2;
	// columns seen in this row, saturates at two
	logic [1:0] seen;
	logic [8:0] window;

	// bit 3i+j is row i, column start+j
	// col_m2 is the oldest, so it is the start column
	always_comb begin
		for (int i = 0; i < 3; i++) begin
			window[3*i] = col_m2[i];
			window[3*i+1] = col_m1[i];
			window[3*i+2] = sample.pix[i];
		end
	end

	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			seen <= '0;
			col_m1 <= '0;
			col_m2 <= '0;
			item <= '0;
		end else begin
			// full window only from the third column on
			item.valid <= sample.valid && (seen == 2'd2);
			item.col <= sample.col - COL_W'(2);
			item.waddr <= sample.waddr;
			item.row_end <= sample.row_end;
			// differing bit means a negative product
			item.bits <= window ^ kernel;
			if (sample.valid) begin
				col_m2 <= col_m1;
				col_m1 <= sample.pix;
				// next sample starts a fresh row
				if (sample.row_end) begin
					seen <= '0;
				end else if (seen != 2'd2) begin
					seen <= seen + 2'd1;
				end
			end
		end
	end

endmodule

// File: conv_ctrl.sv
// sequencer FSM, read addressing, three-row buffer and column sample stream
module conv_ctrl import conv_pkg::*; (
	input logic clk,
	input logic reset_b,
	input logic dut_run,
	input logic [ROW_W-1:0] sram_dut_read_data,
	input logic [ROW_W-1:0] wmem_dut_read_data,
	input logic packer_idle,
	output logic dut_busy,
	output logic [ADDR_W-1:0] dut_sram_read_address,
	output logic [ADDR_W-1:0] dut_wmem_read_address,
	output col_sample_t sample,
	output logic [8:0] kernel
);

	ctrl_state_e state;

	// output row address, counted across the batch
	logic [ADDR_W-1:0] out_addr;
	// rows still to fetch after the first three
	logic [COL_W:0] rows_left;
	// index of the rightmost column
	logic [COL_W-1:0] last_col;
	// sweep column, doubles as drain wait counter
	logic [COL_W-1:0] col;

	// rolling buffer, row0 is the top of the window
	logic [ROW_W-1:0] row0;
	logic [ROW_W-1:0] row1;
	logic [ROW_W-1:0] row2;

	logic end_hit;

	// kernel sits at one fixed word
	assign dut_wmem_read_address = KERNEL_ADDR;

	assign end_hit = (sram_dut_read_data == END_MARKER);

	// one sample per sweep cycle
	always_comb begin
		sample.valid = (state == st_sweep);
		sample.pix = {row2[col], row1[col], row0[col]};
		sample.col = col;
		sample.waddr = out_addr;
		sample.row_end = (col == last_col);
	end

	// read data lags the address by one cycle
	// so the address steps one state ahead of its data
	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			state <= st_idle;
			dut_busy <= 1'b0;
			dut_sram_read_address <= '0;
			out_addr <= '0;
			rows_left <= '0;
			last_col <= '0;
			col <= '0;
			kernel <= '0;
		end else begin
			case (state)
				st_idle: begin
					// address 0 already on the bus
					if (dut_run) begin
						dut_busy <= 1'b1;
						out_addr <= '0;
						dut_sram_read_address <= dut_sram_read_address + 1'b1;
						state <= st_read_rows;
					end
				end
				st_read_rows: begin
					if (end_hit) begin
						// batch done, rewind for the next run
						dut_busy <= 1'b0;
						dut_sram_read_address <= '0;
						state <= st_idle;
					end else begin
						rows_left <= sram_dut_read_data[COL_W:0] - (COL_W + 1)'(3);
						dut_sram_read_address <= dut_sram_read_address + 1'b1;
						state <= st_read_cols;
					end
				end
				st_read_cols: begin
					last_col <= sram_dut_read_data[COL_W-1:0] - 1'b1;
					// kernel taken once per matrix
					kernel <= wmem_dut_read_data[8:0];
					dut_sram_read_address <= dut_sram_read_address + 1'b1;
					state <= st_load_row0;
				end
				st_load_row0: begin
					dut_sram_read_address <= dut_sram_read_address + 1'b1;
					state <= st_load_row1;
				end
				st_load_row1: begin
					dut_sram_read_address <= dut_sram_read_address + 1'b1;
					state <= st_load_row2;
				end
				st_load_row2: begin
					// address now points past row2 and stays there
					col <= '0;
					state <= st_sweep;
				end
				st_sweep: begin
					if (col == last_col) begin
						col <= '0;
						out_addr <= out_addr + 1'b1;
						if (rows_left == '0) begin
							state <= st_drain;
						end else begin
							rows_left <= rows_left - 1'b1;
							state <= st_next_row;
						end
					end else begin
						col <= col + 1'b1;
					end
				end
				st_next_row: begin
					// prefetched row captured below
					dut_sram_read_address <= dut_sram_read_address + 1'b1;
					state <= st_sweep;
				end
				st_drain: begin
					// last samples still ahead of the packer for a few cycles
					if (col != COL_W'(2)) begin
						col <= col + 1'b1;
					end else if (packer_idle) begin
						col <= '0;
						dut_sram_read_address <= dut_sram_read_address + 1'b1;
						state <= st_read_rows;
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	// row buffer fill and shift up
	always_ff @(posedge clk) begin
		case (state)
			st_load_row0: begin
				row0 <= sram_dut_read_data;
			end
			st_load_row1: begin
				row1 <= sram_dut_read_data;
			end
			st_load_row2: begin
				row2 <= sram_dut_read_data;
			end
			st_next_row: begin
				row0 <= row1;
				row1 <= row2;
				row2 <= sram_dut_read_data;
			end
			default: begin
			end
		endcase
	end

endmodule

// File: conv_pkg.sv
// widths, memory map constants, sequencer states and pipeline structs
package conv_pkg;

	// address and row word widths
	localparam int ADDR_W = 12;
	localparam int ROW_W = 16;
	localparam int COL_W = 4;

	// fixed kernel location in weight memory
	localparam logic [ADDR_W-1:0] KERNEL_ADDR = 12'd1;
	// rows word that closes a batch
	localparam logic [ROW_W-1:0] END_MARKER = 16'h00FF;
	// five of nine negative products make the window negative
	localparam int MISMATCH_LIMIT = 5;

	typedef enum logic [3:0] {
		st_idle,
		st_read_rows,
		st_read_cols,
		st_load_row0,
		st_load_row1,
		st_load_row2,
		st_sweep,
		st_next_row,
		st_drain
	} ctrl_state_e;

	// one column of the three buffered rows
	typedef struct packed {
		logic valid;
		logic [2:0] pix;
		logic [COL_W-1:0] col;
		logic [ADDR_W-1:0] waddr;
		logic row_end;
	} col_sample_t;

	// one window, bits hold mismatches then partial sums
	typedef struct packed {
		logic valid;
		logic [COL_W-1:0] col;
		logic [ADDR_W-1:0] waddr;
		logic row_end;
		logic [8:0] bits;
	} vote_item_t;

	// one decided output pixel
	typedef struct packed {
		logic valid;
		logic [COL_W-1:0] col;
		logic [ADDR_W-1:0] waddr;
		logic row_end;
		logic pos;
	} result_t;

endpackage
